/* vlog.f */
+incdir+include
src/dac_pkg.sv
src/dac_ddr_serializer.sv
src/spi_master.sv
src/dac_cmd_controller.sv
src/dac_iface_top.sv
verification/dac_iface_sva.sv
verification/dac_iface_tb.sv

/* Makefile */
# Verilator build and run for the DAC interface testbench
VERILATOR ?= verilator
TOP       ?= dac_iface_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/dac_iface_tb.sv */
// Testbench for dac_iface_top with an SPI register slave model and directed tests
`include "dac_consts.svh"

module dac_iface_tb;
	timeunit 1ns;
	timeprecision 1ns;

	// DUT inputs
	logic                 clk_in      = 1'b0;
	logic                 reset       = 1'b1;
	dac_pkg::dac_sample_t dac0_sample = '0;
	dac_pkg::dac_sample_t dac1_sample = '0;
	logic                 cmd_valid   = 1'b0;
	logic                 cmd_write   = 1'b0;
	dac_pkg::reg_addr_t   cmd_addr    = '0;
	dac_pkg::reg_data_t   cmd_wdata   = '0;
	logic                 spi_sdi     = 1'b0;

	// DUT outputs
	dac_pkg::lane_word_t lane_p;
	dac_pkg::lane_word_t lane_n;
	logic                cmd_ready;
	logic                rsp_valid;
	dac_pkg::reg_data_t  rsp_rdata;
	logic                dac_reset;
	logic                spi_scs;
	logic                spi_sck;
	logic                spi_sdo;

	// SPI slave model state
	dac_pkg::reg_data_t slave_mem [32];
	logic               sck_q;
	logic               scs_q;
	logic [15:0]        slave_shift;
	dac_pkg::reg_addr_t slave_addr;
	int                 slave_bits;
	int                 frame_count;
	logic               last_read;
	dac_pkg::reg_addr_t last_addr;
	dac_pkg::reg_data_t last_data;
	logic [2:0]         sdi_index;

	// 100 ns clock
	initial begin
		forever #50 clk_in = ~clk_in;
	end

	dac_iface_top dut0 (
		.clk_in      (clk_in),
		.reset       (reset),
		.dac0_sample (dac0_sample),
		.dac1_sample (dac1_sample),
		.lane_p      (lane_p),
		.lane_n      (lane_n),
		.cmd_valid   (cmd_valid),
		.cmd_write   (cmd_write),
		.cmd_addr    (cmd_addr),
		.cmd_wdata   (cmd_wdata),
		.cmd_ready   (cmd_ready),
		.rsp_valid   (rsp_valid),
		.rsp_rdata   (rsp_rdata),
		.dac_reset   (dac_reset),
		.spi_scs     (spi_scs),
		.spi_sck     (spi_sck),
		.spi_sdo     (spi_sdo),
		.spi_sdi     (spi_sdi)
	);

	bind dac_iface_top dac_iface_sva sva0 (
		.clk_in    (clk_in),
		.reset     (reset),
		.spi_scs   (spi_scs),
		.spi_sck   (spi_sck),
		.cmd_ready (cmd_ready),
		.lane_p    (lane_p),
		.lane_n    (lane_n)
	);

	////////////////////////////////////////////////////////////////////////////
	// SPI register slave

	// sck and scs edges are seen one clk_in cycle late, well inside a half period
	always @(posedge clk_in) begin
		if (reset) begin
			// Power-on content is address XOR 0xA5
			for (int i = 0; i < 32; i++) begin
				slave_mem[i] = 8'(i) ^ 8'ha5;
			end
			sck_q       = 1'b0;
			scs_q       = 1'b1;
			slave_bits  = 0;
			frame_count = 0;
			spi_sdi     <= 1'b0;
		end else begin
			if (scs_q && !spi_scs) begin
				slave_bits = 0;
			end
			// sdo is taken on sck rise
			if (!spi_scs && spi_sck && !sck_q) begin
				slave_shift = {slave_shift[14:0], spi_sdo};
				slave_bits  = slave_bits + 1;
				if (slave_bits == 8) begin
					slave_addr = slave_shift[4:0];
				end
			end
			// Data byte out MSB first, one bit per falling edge
			if (!spi_scs && !spi_sck && sck_q && slave_bits >= 8 && slave_bits < 16) begin
				sdi_index = 3'(15 - slave_bits);
				spi_sdi <= slave_mem[slave_addr][sdi_index];
			end
			// Full frame seen when scs returns high
			if (!scs_q && spi_scs && slave_bits == 16) begin
				frame_count++;
				last_read = slave_shift[15];
				last_addr = slave_shift[12:8];
				last_data = slave_shift[7:0];
				if (!last_read) begin
					slave_mem[last_addr] = last_data;
				end
			end
			sck_q = spi_sck;
			scs_q = spi_scs;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checking helpers

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else stop_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
			test, expected, actual));
	endtask

	// Sampling clock, data clock, then D15..D0
	function automatic dac_pkg::lane_word_t lane_word(input logic smp_clk,
		input logic dat_clk, input dac_pkg::dac_sample_t data);
		return {smp_clk, dat_clk, data};
	endfunction

	task automatic check_lanes(input string test, input dac_pkg::lane_word_t expected);
		dac_pkg::lane_word_t inverted;
		inverted = ~expected;
		check_value(test, 32'(expected), 32'(lane_p));
		check_value(test, 32'(inverted), 32'(lane_n));
	endtask

	task automatic wait_cmd_ready(input string test);
		int timer;
		timer = 0;
		do begin
			@(posedge clk_in);
			timer++;
			if (timer > 1000) begin
				stop_run($sformatf("%s: timed out waiting for cmd_ready", test));
			end
		end while (cmd_ready !== 1'b1);
	endtask

	// One get or set, busy check while the frame runs
	task automatic run_command(input string test, input logic write,
		input dac_pkg::reg_addr_t addr, input dac_pkg::reg_data_t wdata,
		output dac_pkg::reg_data_t rdata);
		int timer;
		wait_cmd_ready(test);
		cmd_valid <= 1'b1;
		cmd_write <= write;
		cmd_addr  <= addr;
		cmd_wdata <= wdata;
		// Ready already high, so accepted on this edge
		@(posedge clk_in);
		cmd_valid <= 1'b0;
		timer = 0;
		do begin
			@(posedge clk_in);
			timer++;
			if (timer > 1000) begin
				stop_run($sformatf("%s: timed out waiting for rsp_valid", test));
			end
			if (rsp_valid !== 1'b1) begin
				assert (cmd_ready === 1'b0)
				else stop_run($sformatf("%s: cmd_ready high with a command in flight", test));
			end
		end while (rsp_valid !== 1'b1);
		rdata = rsp_rdata;
		// Frame on the wire: read flag for gets, address, zero data for gets
		check_value(test, 32'(!write), 32'(last_read));
		check_value(test, 32'(addr), 32'(last_addr));
		check_value(test, 32'(write ? wdata : 8'h00), 32'(last_data));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic init_sequence();
		int timer;
		int high_cycles;
		timer = 0;
		high_cycles = 0;
		while (dac_reset !== 1'b1) begin
			@(posedge clk_in);
			timer++;
			if (timer > 10) begin
				stop_run("init_sequence: dac_reset never went high after reset");
			end
		end
		while (dac_reset === 1'b1) begin
			high_cycles++;
			@(posedge clk_in);
			if (high_cycles > `DAC_RESET_CYCLES + 10) begin
				stop_run("init_sequence: dac_reset stuck high");
			end
		end
		check_value("init_sequence", 32'(`DAC_RESET_CYCLES), 32'(high_cycles));
		check_value("init_sequence", 32'(0), 32'(frame_count));
		wait_cmd_ready("init_sequence");
		// Exactly one frame, the sample-delay write
		check_value("init_sequence", 32'(1), 32'(frame_count));
		check_value("init_sequence", 32'(0), 32'(last_read));
		check_value("init_sequence", 32'(`DAC_SMP_DLY_ADDR), 32'(last_addr));
		check_value("init_sequence", 32'(`DAC_SMP_DLY), 32'(last_data));
	endtask

	task automatic ddr_frame();
		dac_pkg::dac_sample_t s0;
		dac_pkg::dac_sample_t s1;
		s0 = dac_pkg::dac_sample_t'($urandom);
		s1 = dac_pkg::dac_sample_t'($urandom);
		@(posedge clk_in);
		dac0_sample <= s0;
		dac1_sample <= s1;
		repeat (3) @(posedge clk_in);
		#25;
		check_lanes("ddr_frame", lane_word(1'b0, 1'b1, s0));
		@(negedge clk_in);
		#25;
		check_lanes("ddr_frame", lane_word(1'b1, 1'b0, s1));
	endtask

	// Pair driven before edge k shows up after edge k+1
	task automatic ddr_stream();
		dac_pkg::dac_sample_t ch0 [20];
		dac_pkg::dac_sample_t ch1 [20];
		for (int j = 0; j < 22; j++) begin
			@(posedge clk_in);
			if (j < 20) begin
				ch0[j] = dac_pkg::dac_sample_t'($urandom);
				ch1[j] = dac_pkg::dac_sample_t'($urandom);
				dac0_sample <= ch0[j];
				dac1_sample <= ch1[j];
			end
			if (j >= 2) begin
				#25;
				check_lanes("ddr_stream", lane_word(1'b0, 1'b1, ch0[j - 2]));
				@(negedge clk_in);
				#25;
				check_lanes("ddr_stream", lane_word(1'b1, 1'b0, ch1[j - 2]));
			end
		end
	endtask

	// Four distinct addresses in the lower half
	task automatic set_then_get();
		dac_pkg::reg_addr_t addrs [4];
		dac_pkg::reg_data_t vals [4];
		dac_pkg::reg_data_t rdata;
		int base;
		base = int'($urandom_range(15, 0));
		for (int i = 0; i < 4; i++) begin
			addrs[i] = dac_pkg::reg_addr_t'((base + 4 * i) % 16);
			vals[i]  = dac_pkg::reg_data_t'($urandom);
			run_command("set_then_get", 1'b1, addrs[i], vals[i], rdata);
			check_value("set_then_get", 32'(vals[i]), 32'(slave_mem[addrs[i]]));
		end
		for (int i = 0; i < 4; i++) begin
			run_command("set_then_get", 1'b0, addrs[i], 8'h00, rdata);
			check_value("set_then_get", 32'(vals[i]), 32'(rdata));
		end
	endtask

	// Upper half is never written
	task automatic get_default_and_busy();
		dac_pkg::reg_addr_t addr;
		dac_pkg::reg_data_t rdata;
		dac_pkg::reg_data_t expected;
		addr = dac_pkg::reg_addr_t'(16 + $urandom_range(15, 0));
		run_command("get_default_and_busy", 1'b0, addr, 8'h00, rdata);
		expected = 8'(addr) ^ 8'ha5;
		check_value("get_default_and_busy", 32'(expected), 32'(rdata));
	endtask

	initial begin
		void'($urandom(16864));
		repeat (5) @(posedge clk_in);
		reset <= 1'b0;
		init_sequence();
		ddr_frame();
		ddr_stream();
		set_then_get();
		get_default_and_busy();
		$display("Test passed");
		$finish;
	end

endmodule

/* verification/dac_iface_sva.sv */
// Bound SVA checks on the SPI pins, the command handshake and the DDR lanes
module dac_iface_sva (
	input logic                clk_in,
	input logic                reset,
	input logic                spi_scs,
	input logic                spi_sck,
	input logic                cmd_ready,
	input dac_pkg::lane_word_t lane_p,
	input dac_pkg::lane_word_t lane_n
);
	timeunit 1ns;
	timeprecision 1ns;

	////////////////////////////////////////////////////////////////////////////
	// SPI and command handshake

	// sck idles low outside a frame
	sck_idle_low: assert property (@(posedge clk_in) disable iff (reset)
		spi_scs |-> !spi_sck)
		else $error("spi_sck high while spi_scs is high");

	// Host may only hand over a command while no frame is on the wire
	ready_only_idle: assert property (@(posedge clk_in) disable iff (reset)
		cmd_ready |-> spi_scs)
		else $error("cmd_ready high during an SPI frame");

	////////////////////////////////////////////////////////////////////////////
	// DDR lanes

	// n leg mirrors p leg
	lane_pair: assert property (@(posedge clk_in) disable iff (reset)
		lane_n == ~lane_p)
		else $error("lane_n is not the complement of lane_p");

	// Clock markers always opposite once the DDR stage has loaded
	lane_markers: assert property (@(posedge clk_in) disable iff (reset)
		!$past(reset) |-> (lane_p[17] != lane_p[16]))
		else $error("sampling clock and data clock lanes are equal");

endmodule

/* src/dac_iface_top.sv */
// Top level joining the DDR serializer, the command controller and the SPI engine
`include "dac_consts.svh"

module dac_iface_top (
	input  logic                 clk_in,
	input  logic                 reset,
	input  dac_pkg::dac_sample_t dac0_sample,
	input  dac_pkg::dac_sample_t dac1_sample,
	output dac_pkg::lane_word_t  lane_p,
	output dac_pkg::lane_word_t  lane_n,
	input  logic                 cmd_valid,
	input  logic                 cmd_write,
	input  dac_pkg::reg_addr_t   cmd_addr,
	input  dac_pkg::reg_data_t   cmd_wdata,
	output logic                 cmd_ready,
	output logic                 rsp_valid,
	output dac_pkg::reg_data_t   rsp_rdata,
	output logic                 dac_reset,
	output logic                 spi_scs,
	output logic                 spi_sck,
	output logic                 spi_sdo,
	input  logic                 spi_sdi
);

	// Controller to SPI engine link
	logic               spi_valid;
	dac_pkg::spi_word_t spi_tx;
	logic               spi_ready;
	logic               spi_done;
	dac_pkg::reg_data_t spi_rx;

	////////////////////////////////////////////////////////////////////////////
	// Sample streaming

	dac_ddr_serializer ser0 (
		.clk_in      (clk_in),
		.reset       (reset),
		.dac0_sample (dac0_sample),
		.dac1_sample (dac1_sample),
		.lane_p      (lane_p),
		.lane_n      (lane_n)
	);

	////////////////////////////////////////////////////////////////////////////
	// Configuration path

	dac_cmd_controller ctrl0 (
		.clk_in    (clk_in),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_write (cmd_write),
		.cmd_addr  (cmd_addr),
		.cmd_wdata (cmd_wdata),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.dac_reset (dac_reset),
		.spi_valid (spi_valid),
		.spi_tx    (spi_tx),
		.spi_ready (spi_ready),
		.spi_done  (spi_done),
		.spi_rx    (spi_rx)
	);

	// sck at clk_in / (2 * SPI_CLK_DIV)
	spi_master #(
		.spi_clk_div (`SPI_CLK_DIV)
	) spi0 (
		.clk_in    (clk_in),
		.reset     (reset),
		.spi_valid (spi_valid),
		.spi_tx    (spi_tx),
		.spi_ready (spi_ready),
		.spi_done  (spi_done),
		.spi_rx    (spi_rx),
		.spi_scs   (spi_scs),
		.spi_sck   (spi_sck),
		.spi_sdo   (spi_sdo),
		.spi_sdi   (spi_sdi)
	);

endmodule

/* src/dac_cmd_controller.sv */
// Controller FSM for the DAC reset pulse, the startup delay write and host get/set commands
`include "dac_consts.svh"

module dac_cmd_controller (
	input  logic               clk_in,
	input  logic               reset,
	input  logic               cmd_valid,
	input  logic               cmd_write,
	input  dac_pkg::reg_addr_t cmd_addr,
	input  dac_pkg::reg_data_t cmd_wdata,
	output logic               cmd_ready,
	output logic               rsp_valid,
	output dac_pkg::reg_data_t rsp_rdata,
	output logic               dac_reset,
	output logic               spi_valid,
	output dac_pkg::spi_word_t spi_tx,
	input  logic               spi_ready,
	input  logic               spi_done,
	input  dac_pkg::reg_data_t spi_rx
);

	localparam int cnt_w = $clog2(`DAC_RESET_CYCLES + 1);

	dac_pkg::ctrl_state_t state;
	logic [cnt_w-1:0]     rst_cnt;

	// Frame layout: read flag, two zero bits, address, data
	function automatic dac_pkg::spi_word_t make_frame(
		input logic               read,
		input dac_pkg::reg_addr_t addr,
		input dac_pkg::reg_data_t data
	);
		dac_pkg::spi_word_t frame;
		frame = {3'b000, addr, data};
		frame[`SPI_READ_BIT] = read;
		return frame;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk_in) begin
		if (reset) begin
			state     <= dac_pkg::reset_pulse;
			rst_cnt   <= cnt_w'(`DAC_RESET_CYCLES);
			dac_reset <= 1'b0;
			cmd_ready <= 1'b0;
			rsp_valid <= 1'b0;
			spi_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				// Hold the DAC reset pin, one count per cycle
				dac_pkg::reset_pulse: begin
					if (rst_cnt == '0) begin
						dac_reset <= 1'b0;
						state     <= dac_pkg::load_delay;
					end else begin
						dac_reset <= 1'b1;
						rst_cnt   <= rst_cnt - 1'b1;
					end
				end
				// Sample-delay register write
				dac_pkg::load_delay: begin
					spi_tx <= make_frame(1'b0,
						dac_pkg::reg_addr_t'(`DAC_SMP_DLY_ADDR),
						dac_pkg::reg_data_t'(`DAC_SMP_DLY));
					spi_valid <= 1'b1;
					state     <= dac_pkg::send_delay;
				end
				// Hand off, then wait for the frame to finish
				dac_pkg::send_delay: begin
					if (spi_ready) begin
						spi_valid <= 1'b0;
					end
					if (spi_done) begin
						cmd_ready <= 1'b1;
						state     <= dac_pkg::idle;
					end
				end
				// Host command accept, gets carry zero data
				dac_pkg::idle: begin
					if (cmd_valid && cmd_ready) begin
						cmd_ready <= 1'b0;
						spi_tx    <= make_frame(!cmd_write, cmd_addr,
							cmd_write ? cmd_wdata : '0);
						spi_valid <= 1'b1;
						state     <= dac_pkg::send_cmd;
					end
				end
				dac_pkg::send_cmd: begin
					if (spi_ready) begin
						spi_valid <= 1'b0;
						state     <= dac_pkg::wait_cmd;
					end
				end
				// Byte shifted in goes back with the response
				dac_pkg::wait_cmd: begin
					if (spi_done) begin
						rsp_valid <= 1'b1;
						rsp_rdata <= spi_rx;
						cmd_ready <= 1'b1;
						state     <= dac_pkg::idle;
					end
				end
				default: begin
					state <= dac_pkg::reset_pulse;
				end
			endcase
		end
	end

endmodule

/* src/spi_master.sv */
// SPI engine shifting out one 16-bit frame and capturing the returned byte
`include "dac_consts.svh"

module spi_master #(
	parameter int spi_clk_div = `SPI_CLK_DIV
) (
	input  logic                clk_in,
	input  logic                reset,
	input  logic                spi_valid,
	input  dac_pkg::spi_word_t  spi_tx,
	output logic                spi_ready,
	output logic                spi_done,
	output dac_pkg::reg_data_t  spi_rx,
	output logic                spi_scs,
	output logic                spi_sck,
	output logic                spi_sdo,
	input  logic                spi_sdi
);

	localparam int div_w = $clog2(spi_clk_div + 1);
	localparam int bit_w = $clog2(`SPI_WORD_BITS);
	localparam int rx_w  = $bits(dac_pkg::reg_data_t);

	// Half period timer and sck pulse count
	logic [div_w-1:0] div_cnt;
	logic [bit_w-1:0] bit_cnt;
	logic             div_last;
	logic             bit_last;

	// Outgoing bits leave the top, sampled bits enter the bottom
	dac_pkg::spi_word_t shift_reg;
	logic               sdi_bit;

	assign div_last = (div_cnt == div_w'(spi_clk_div - 1));
	assign bit_last = (bit_cnt == bit_w'(`SPI_WORD_BITS - 1));

	// MSB first
	assign spi_sdo = shift_reg[`SPI_WORD_BITS-1];

	////////////////////////////////////////////////////////////////////////////
	// Frame control

	always_ff @(posedge clk_in) begin
		if (reset) begin
			spi_ready <= 1'b1;
			spi_done  <= 1'b0;
			spi_scs   <= 1'b1;
			spi_sck   <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
		end else begin
			spi_done <= 1'b0;
			if (spi_ready) begin
				// Start of frame, first half period is sck low
				if (spi_valid) begin
					spi_ready <= 1'b0;
					spi_scs   <= 1'b0;
					div_cnt   <= '0;
					bit_cnt   <= '0;
				end
			end else if (div_last) begin
				div_cnt <= '0;
				spi_sck <= ~spi_sck;
				if (spi_sck && bit_last) begin
					// 16th falling edge ends the frame
					spi_scs   <= 1'b1;
					spi_ready <= 1'b1;
					spi_done  <= 1'b1;
				end else if (spi_sck) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Data path

	always_ff @(posedge clk_in) begin
		if (spi_ready && spi_valid) begin
			shift_reg <= spi_tx;
		end else if (!spi_ready && div_last) begin
			if (!spi_sck) begin
				// sck about to rise, take sdi
				sdi_bit <= spi_sdi;
			end else begin
				// sck about to fall, next sdo bit
				shift_reg <= {shift_reg[`SPI_WORD_BITS-2:0], sdi_bit};
				// Data byte is the last 8 bits sampled
				if (bit_last) begin
					spi_rx <= {shift_reg[rx_w-2:0], sdi_bit};
				end
			end
		end
	end

endmodule

/* src/dac_ddr_serializer.sv */
// DDR serializer packing both DAC channels with clock markers onto p/n lanes
module dac_ddr_serializer (
	input  logic                 clk_in,
	input  logic                 reset,
	input  dac_pkg::dac_sample_t dac0_sample,
	input  dac_pkg::dac_sample_t dac1_sample,
	output dac_pkg::lane_word_t  lane_p,
	output dac_pkg::lane_word_t  lane_n
);

	////////////////////////////////////////////////////////////////////////////
	// Pack stage

	// Rise word for channel 0, fall word for channel 1
	dac_pkg::lane_word_t pack_rise;
	dac_pkg::lane_word_t pack_fall;

	// DDR output registers
	dac_pkg::lane_word_t ddr_rise;
	dac_pkg::lane_word_t ddr_fall;

	// Sampling clock low and data clock high in the rise half
	// Both markers flip for the fall half
	always_ff @(posedge clk_in) begin
		pack_rise <= {1'b0, 1'b1, dac0_sample};
		pack_fall <= {1'b1, 1'b0, dac1_sample};
	end

	////////////////////////////////////////////////////////////////////////////
	// DDR stage

	// Both halves loaded together on the rising edge
	// Fall half waits in its register until clk_in drops, like an
	// opposite-edge output register fed from this clock domain
	always_ff @(posedge clk_in) begin
		if (reset) begin
			ddr_rise <= '0;
			ddr_fall <= '0;
		end else begin
			ddr_rise <= pack_rise;
			ddr_fall <= pack_fall;
		end
	end

	// Output mux on clk_in phase
	// High phase carries channel 0, low phase channel 1
	always_comb begin
		if (clk_in) begin
			lane_p = ddr_rise;
		end else begin
			lane_p = ddr_fall;
		end
	end

	// Complement leg of each differential pair
	assign lane_n = ~lane_p;

endmodule

/* src/dac_pkg.sv */
// Package dac_pkg with sample, lane, SPI word, register and controller state types
`include "dac_consts.svh"

package dac_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path types

	// One signed sample, D15 is the MSB
	typedef logic signed [`DAC_WIDTH-1:0] dac_sample_t;

	// One DDR half-cycle across all lanes
	// Lane 17 sampling clock, lane 16 data clock, 15:0 data
	typedef logic [`DAC_LANES-1:0] lane_word_t;

	////////////////////////////////////////////////////////////////////////////
	// Register access types

	// Read flag, two zero bits, address, data
	typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Controller FSM
	typedef enum logic [2:0] {
		reset_pulse,
		load_delay,
		send_delay,
		idle,
		send_cmd,
		wait_cmd
	} ctrl_state_t;

endpackage

/* include/dac_consts.svh */
// Widths, lane count, reset pulse length, SPI framing and startup delay value
`ifndef DAC_CONSTS_SVH
`define DAC_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Sample path

// Signed sample width per DAC channel
`define DAC_WIDTH 16
// 16 data lanes plus sampling clock and data clock
`define DAC_LANES 18

////////////////////////////////////////////////////////////////////////////
// DAC control

// DAC reset pin high time, in clk_in cycles
`define DAC_RESET_CYCLES 255

// SPI frame length in bits
`define SPI_WORD_BITS 16
// clk_in cycles per sck half period
`define SPI_CLK_DIV 5
// Read flag position, first bit on the wire
`define SPI_READ_BIT 15

// Sample-delay register and its startup value
`define DAC_SMP_DLY_ADDR 5
`define DAC_SMP_DLY 0

`endif
